//--- hdl/core_l15_pkg.sv
package core_l15_pkg;

	// widths with a meaning of their own
	typedef logic [31:0] addr_t;    // byte address
	typedef logic [31:0] word_t;    // instruction or data word
	typedef logic [63:0] line_t;    // half of an L1.5 return, also store data
	typedef logic [4:0]  rqtype_t;  // L1.5 request type
	typedef logic [3:0]  rettype_t; // L1.5 return type
	typedef logic [2:0]  size_t;    // L1.5 request size

	// request codes towards the L1.5
	localparam rqtype_t LOAD_RQ  = 5'b00000;
	localparam rqtype_t IFILL_RQ = 5'b10000;
	localparam rqtype_t STORE_RQ = 5'b00001;

	// return codes from the L1.5
	localparam rettype_t LOAD_RET  = 4'b0000;
	localparam rettype_t IFILL_RET = 4'b0001;
	localparam rettype_t ST_ACK    = 4'b0100;
	localparam rettype_t INT_RET   = 4'b0111; // wake-up after reset

	// 4-byte access
	localparam size_t WORD_SIZE = 3'b010;

	localparam addr_t RESET_PC  = 32'h4000_0000;
	localparam word_t NOP_INSTR = 32'h0000_0033; // add x0, x0, x0

	// fetch unit
	typedef enum logic [1:0] {
		f_req,
		f_wait_ack,
		f_resp
	} fetch_state_t;

	// data port
	typedef enum logic [1:0] {
		p_idle,
		p_req,
		p_wait_ack,
		p_resp
	} port_state_t;

	// arbiter, a_sleep until the wake-up return
	typedef enum logic [1:0] {
		a_sleep,
		a_idle,
		a_fetch,
		a_data
	} arb_state_t;

endpackage

//--- hdl/fetch_unit.sv
module fetch_unit (
	input  logic                 clk,
	input  logic                 nrst,
	input  logic                 stall,
	input  logic                 redirect,
	input  core_l15_pkg::addr_t  target,
	input  logic                 exception_pending,
	input  core_l15_pkg::addr_t  epc,
	input  logic                 grant_hdr,
	input  logic                 grant_ack,
	input  logic                 resp_valid,
	input  core_l15_pkg::word_t  resp_word,
	output logic                 fetch_req,
	output core_l15_pkg::addr_t  fetch_addr,
	output core_l15_pkg::word_t  instr,
	output core_l15_pkg::addr_t  pc,
	output logic                 instr_valid,
	output logic                 instruction_addr_misaligned
);

	core_l15_pkg::fetch_state_t state;
	core_l15_pkg::addr_t        pc_reg;   // address of the word in flight
	core_l15_pkg::addr_t        pend_pc;  // target saved while a request is out
	core_l15_pkg::addr_t        new_pc;
	logic                       discard;  // outstanding response is stale
	logic                       req_lock; // request raised but header not yet taken
	logic                       jump;
	logic                       busy;
	logic                       resp_here;

	// exception wins over redirect
	assign jump   = exception_pending | redirect;
	assign new_pc = exception_pending ? epc : target;

	// once raised the request stays up, even if a stall shows up meanwhile
	assign fetch_req = (state == core_l15_pkg::f_req) && (!stall || req_lock);

	// a request is in the arbiter or in the L1.5
	assign busy = fetch_req || (state != core_l15_pkg::f_req);

	assign resp_here = (state == core_l15_pkg::f_resp) && resp_valid;

	assign fetch_addr = pc_reg;
	assign pc         = pc_reg;

	// a jump in the response cycle kills that word as well
	assign instr_valid = resp_here && !discard && !jump;
	assign instr       = instr_valid ? resp_word : core_l15_pkg::NOP_INSTR;

	assign instruction_addr_misaligned = |pc_reg[1:0];

	always_ff @(posedge clk, negedge nrst)
	begin
		if (!nrst)
		begin
			state    <= core_l15_pkg::f_req;
			req_lock <= 1'b0;
		end
		else
		begin
			req_lock <= fetch_req && !grant_hdr;
			case (state)
				core_l15_pkg::f_req:
				begin
					if (fetch_req && grant_hdr)
					begin
						// ack may come together with the header
						if (grant_ack)
							state <= core_l15_pkg::f_resp;
						else
							state <= core_l15_pkg::f_wait_ack;
					end
				end
				core_l15_pkg::f_wait_ack:
				begin
					if (grant_ack)
						state <= core_l15_pkg::f_resp;
				end
				core_l15_pkg::f_resp:
				begin
					if (resp_valid)
						state <= core_l15_pkg::f_req;
				end
				default:
					state <= core_l15_pkg::f_req;
			endcase
		end
	end

	// pc and discard bookkeeping
	always_ff @(posedge clk, negedge nrst)
	begin
		if (!nrst)
		begin
			pc_reg  <= core_l15_pkg::RESET_PC;
			discard <= 1'b0;
		end
		else if (resp_here)
		begin
			discard <= 1'b0;
			if (jump)
				pc_reg <= new_pc;
			else if (discard)
				pc_reg <= pend_pc; // stale word dropped, go to saved target
			else
				pc_reg <= pc_reg + 32'd4;
		end
		else if (jump && busy)
		begin
			discard <= 1'b1;
		end
		else if (jump)
		begin
			pc_reg <= new_pc; // nothing out, take target at once
		end
	end

	// latest target wins if several arrive before the response
	always_ff @(posedge clk)
	begin
		if (jump && busy && !resp_here)
			pend_pc <= new_pc;
	end

	// the arbiter latches the address on its own, so it must not move under it
	addr_hold: assert property (@(posedge clk) disable iff (!nrst)
		fetch_req && !grant_hdr |=> fetch_req && $stable(fetch_addr));

endmodule

//--- hdl/data_port.sv
module data_port (
	input  logic                  clk,
	input  logic                  nrst,
	input  logic                  mem_rd,
	input  logic                  mem_wr,
	input  core_l15_pkg::addr_t   mem_addr,
	input  core_l15_pkg::word_t   mem_wdata,
	input  logic                  grant_hdr,
	input  logic                  grant_ack,
	input  logic                  resp_valid,
	input  core_l15_pkg::word_t   resp_word,
	output logic                  mem_busy,
	output core_l15_pkg::word_t   mem_rdata,
	output logic                  mem_done,
	output logic                  data_req,
	output core_l15_pkg::rqtype_t data_rqtype,
	output core_l15_pkg::addr_t   data_addr,
	output core_l15_pkg::line_t   data_payload
);

	core_l15_pkg::port_state_t state;
	core_l15_pkg::addr_t       addr_q;
	core_l15_pkg::word_t       wdata_q;
	core_l15_pkg::word_t       wdata_swap;
	core_l15_pkg::word_t       rdata_q;
	logic                      store_q;
	logic                      done_q;
	logic                      accept;

	assign accept = (state == core_l15_pkg::p_idle) && (mem_rd || mem_wr);

	assign mem_busy    = (state != core_l15_pkg::p_idle);
	assign data_req    = (state == core_l15_pkg::p_req);
	assign data_rqtype = store_q ? core_l15_pkg::STORE_RQ : core_l15_pkg::LOAD_RQ;
	assign data_addr   = addr_q;

	// L1.5 takes big-endian data, word copied into both halves
	assign wdata_swap   = {wdata_q[7:0], wdata_q[15:8], wdata_q[23:16], wdata_q[31:24]};
	assign data_payload = {wdata_swap, wdata_swap};

	assign mem_rdata = rdata_q;
	assign mem_done  = done_q;

	always_ff @(posedge clk, negedge nrst)
	begin
		if (!nrst)
		begin
			state   <= core_l15_pkg::p_idle;
			store_q <= 1'b0;
			done_q  <= 1'b0;
		end
		else
		begin
			done_q <= (state == core_l15_pkg::p_resp) && resp_valid;
			case (state)
				core_l15_pkg::p_idle:
				begin
					if (accept)
					begin
						state   <= core_l15_pkg::p_req;
						store_q <= mem_wr;
					end
				end
				core_l15_pkg::p_req:
				begin
					if (grant_hdr)
						state <= grant_ack ? core_l15_pkg::p_resp : core_l15_pkg::p_wait_ack;
				end
				core_l15_pkg::p_wait_ack:
				begin
					if (grant_ack)
						state <= core_l15_pkg::p_resp;
				end
				core_l15_pkg::p_resp:
				begin
					if (resp_valid)
						state <= core_l15_pkg::p_idle; // load data or store ack back
				end
				default:
					state <= core_l15_pkg::p_idle;
			endcase
		end
	end

	always_ff @(posedge clk)
	begin
		if (accept)
		begin
			addr_q  <= mem_addr;
			wdata_q <= mem_wdata;
		end
		if ((state == core_l15_pkg::p_resp) && resp_valid && !store_q)
			rdata_q <= resp_word;
	end

	rd_wr_excl: assert property (@(posedge clk) disable iff (!nrst) !(mem_rd && mem_wr));

endmodule

//--- hdl/l15_arbiter.sv
module l15_arbiter (
	input  logic                   clk,
	input  logic                   nrst,
	input  logic                   fetch_req,
	input  core_l15_pkg::addr_t    fetch_addr,
	input  logic                   data_req,
	input  core_l15_pkg::rqtype_t  data_rqtype,
	input  core_l15_pkg::addr_t    data_addr,
	input  core_l15_pkg::line_t    data_payload,
	input  logic                   l15_transducer_ack,
	input  logic                   l15_transducer_header_ack,
	input  logic                   l15_transducer_val,
	input  core_l15_pkg::line_t    l15_transducer_data_0,
	input  core_l15_pkg::line_t    l15_transducer_data_1,
	input  core_l15_pkg::rettype_t l15_transducer_returntype,
	output logic                   fetch_grant_hdr,
	output logic                   fetch_grant_ack,
	output logic                   fetch_resp_valid,
	output logic                   data_grant_hdr,
	output logic                   data_grant_ack,
	output logic                   data_resp_valid,
	output core_l15_pkg::word_t    resp_word,
	output core_l15_pkg::rqtype_t  transducer_l15_rqtype,
	output core_l15_pkg::size_t    transducer_l15_size,
	output core_l15_pkg::addr_t    transducer_l15_address,
	output core_l15_pkg::line_t    transducer_l15_data,
	output logic                   transducer_l15_val,
	output logic                   transducer_l15_req_ack
);

	core_l15_pkg::arb_state_t state;
	core_l15_pkg::addr_t      addr_q;
	core_l15_pkg::rqtype_t    rq_q;
	core_l15_pkg::rettype_t   want_ret;
	core_l15_pkg::word_t      lane;
	logic                     hdr_sent; // header taken, waiting for the return
	logic                     own_fetch;
	logic                     own_data;
	logic                     resp_hit;

	assign own_fetch = (state == core_l15_pkg::a_fetch);
	assign own_data  = (state == core_l15_pkg::a_data);

	assign transducer_l15_val     = (own_fetch || own_data) && !hdr_sent;
	assign transducer_l15_rqtype  = own_data ? rq_q : core_l15_pkg::IFILL_RQ;
	assign transducer_l15_size    = core_l15_pkg::WORD_SIZE;
	assign transducer_l15_address = addr_q;
	assign transducer_l15_data    = own_data ? data_payload : '0; // data port holds it stable
	assign transducer_l15_req_ack = l15_transducer_val; // every return consumed at once

	assign fetch_grant_hdr = own_fetch && transducer_l15_val && l15_transducer_header_ack;
	assign data_grant_hdr  = own_data && transducer_l15_val && l15_transducer_header_ack;
	// ack can arrive with the header or any cycle after it
	assign fetch_grant_ack = own_fetch && l15_transducer_ack && (hdr_sent || l15_transducer_header_ack);
	assign data_grant_ack  = own_data && l15_transducer_ack && (hdr_sent || l15_transducer_header_ack);

	always_comb
	begin
		if (own_fetch)
			want_ret = core_l15_pkg::IFILL_RET;
		else if (rq_q == core_l15_pkg::STORE_RQ)
			want_ret = core_l15_pkg::ST_ACK;
		else
			want_ret = core_l15_pkg::LOAD_RET;
	end

	// anything else is acked and dropped
	assign resp_hit = l15_transducer_val && hdr_sent && (own_fetch || own_data)
		&& (l15_transducer_returntype == want_ret);
	assign fetch_resp_valid = resp_hit && own_fetch;
	assign data_resp_valid  = resp_hit && own_data;

	// upper half of each 64-bit return first
	always_comb
	begin
		case (addr_q[3:2])
			2'b00:   lane = l15_transducer_data_0[63:32];
			2'b01:   lane = l15_transducer_data_0[31:0];
			2'b10:   lane = l15_transducer_data_1[63:32];
			default: lane = l15_transducer_data_1[31:0];
		endcase
	end

	assign resp_word = {lane[7:0], lane[15:8], lane[23:16], lane[31:24]};

	always_ff @(posedge clk, negedge nrst)
	begin
		if (!nrst)
		begin
			state    <= core_l15_pkg::a_sleep;
			hdr_sent <= 1'b0;
		end
		else
		begin
			case (state)
				core_l15_pkg::a_sleep:
				begin
					if (l15_transducer_val && (l15_transducer_returntype == core_l15_pkg::INT_RET))
						state <= core_l15_pkg::a_idle;
				end
				core_l15_pkg::a_idle:
				begin
					hdr_sent <= 1'b0;
					if (data_req)
						state <= core_l15_pkg::a_data; // data beats fetch
					else if (fetch_req)
						state <= core_l15_pkg::a_fetch;
				end
				default:
				begin
					// locked to the owner until its return shows up
					if (transducer_l15_val && l15_transducer_header_ack)
						hdr_sent <= 1'b1;
					if (resp_hit)
						state <= core_l15_pkg::a_idle;
				end
			endcase
		end
	end

	always_ff @(posedge clk)
	begin
		if (state == core_l15_pkg::a_idle)
		begin
			addr_q <= data_req ? data_addr : fetch_addr;
			rq_q   <= data_rqtype;
		end
	end

	// request fields hold until the L1.5 takes the header
	val_hold: assert property (@(posedge clk) disable iff (!nrst)
		transducer_l15_val && !l15_transducer_header_ack |=> transducer_l15_val
			&& $stable(transducer_l15_address) && $stable(transducer_l15_rqtype)
			&& $stable(transducer_l15_data));

endmodule

//--- hdl/core_l15_front.sv
module core_l15_front (
	input  logic                   clk,
	input  logic                   nrst,
	// fetch side
	input  logic                   stall,
	input  logic                   redirect,
	input  core_l15_pkg::addr_t    target,
	input  logic                   exception_pending,
	input  core_l15_pkg::addr_t    epc,
	output core_l15_pkg::word_t    instr,
	output core_l15_pkg::addr_t    pc,
	output logic                   instr_valid,
	output logic                   instruction_addr_misaligned,
	// data side
	input  logic                   mem_rd,
	input  logic                   mem_wr,
	input  core_l15_pkg::addr_t    mem_addr,
	input  core_l15_pkg::word_t    mem_wdata,
	output logic                   mem_busy,
	output core_l15_pkg::word_t    mem_rdata,
	output logic                   mem_done,
	// L1.5 request
	output core_l15_pkg::rqtype_t  transducer_l15_rqtype,
	output core_l15_pkg::size_t    transducer_l15_size,
	output core_l15_pkg::addr_t    transducer_l15_address,
	output core_l15_pkg::line_t    transducer_l15_data,
	output logic                   transducer_l15_val,
	input  logic                   l15_transducer_ack,
	input  logic                   l15_transducer_header_ack,
	// L1.5 return
	input  logic                   l15_transducer_val,
	input  core_l15_pkg::line_t    l15_transducer_data_0,
	input  core_l15_pkg::line_t    l15_transducer_data_1,
	input  core_l15_pkg::rettype_t l15_transducer_returntype,
	output logic                   transducer_l15_req_ack
);

	logic                  fetch_req;
	core_l15_pkg::addr_t   fetch_addr;
	logic                  fetch_grant_hdr;
	logic                  fetch_grant_ack;
	logic                  fetch_resp_valid;
	logic                  data_req;
	core_l15_pkg::rqtype_t data_rqtype;
	core_l15_pkg::addr_t   data_addr;
	core_l15_pkg::line_t   data_payload;
	logic                  data_grant_hdr;
	logic                  data_grant_ack;
	logic                  data_resp_valid;
	core_l15_pkg::word_t   resp_word; // shared, qualified by each resp_valid

	fetch_unit u_fetch (
		.clk                         (clk),
		.nrst                        (nrst),
		.stall                       (stall),
		.redirect                    (redirect),
		.target                      (target),
		.exception_pending           (exception_pending),
		.epc                         (epc),
		.grant_hdr                   (fetch_grant_hdr),
		.grant_ack                   (fetch_grant_ack),
		.resp_valid                  (fetch_resp_valid),
		.resp_word                   (resp_word),
		.fetch_req                   (fetch_req),
		.fetch_addr                  (fetch_addr),
		.instr                       (instr),
		.pc                          (pc),
		.instr_valid                 (instr_valid),
		.instruction_addr_misaligned (instruction_addr_misaligned)
	);

	data_port u_data (
		.clk          (clk),
		.nrst         (nrst),
		.mem_rd       (mem_rd),
		.mem_wr       (mem_wr),
		.mem_addr     (mem_addr),
		.mem_wdata    (mem_wdata),
		.grant_hdr    (data_grant_hdr),
		.grant_ack    (data_grant_ack),
		.resp_valid   (data_resp_valid),
		.resp_word    (resp_word),
		.mem_busy     (mem_busy),
		.mem_rdata    (mem_rdata),
		.mem_done     (mem_done),
		.data_req     (data_req),
		.data_rqtype  (data_rqtype),
		.data_addr    (data_addr),
		.data_payload (data_payload)
	);

	l15_arbiter u_arb (
		.clk                       (clk),
		.nrst                      (nrst),
		.fetch_req                 (fetch_req),
		.fetch_addr                (fetch_addr),
		.data_req                  (data_req),
		.data_rqtype               (data_rqtype),
		.data_addr                 (data_addr),
		.data_payload              (data_payload),
		.l15_transducer_ack        (l15_transducer_ack),
		.l15_transducer_header_ack (l15_transducer_header_ack),
		.l15_transducer_val        (l15_transducer_val),
		.l15_transducer_data_0     (l15_transducer_data_0),
		.l15_transducer_data_1     (l15_transducer_data_1),
		.l15_transducer_returntype (l15_transducer_returntype),
		.fetch_grant_hdr           (fetch_grant_hdr),
		.fetch_grant_ack           (fetch_grant_ack),
		.fetch_resp_valid          (fetch_resp_valid),
		.data_grant_hdr            (data_grant_hdr),
		.data_grant_ack            (data_grant_ack),
		.data_resp_valid           (data_resp_valid),
		.resp_word                 (resp_word),
		.transducer_l15_rqtype     (transducer_l15_rqtype),
		.transducer_l15_size       (transducer_l15_size),
		.transducer_l15_address    (transducer_l15_address),
		.transducer_l15_data       (transducer_l15_data),
		.transducer_l15_val        (transducer_l15_val),
		.transducer_l15_req_ack    (transducer_l15_req_ack)
	);

endmodule

//--- testbench/l15_model.sv
module l15_model (
	input  logic                   clk,
	input  logic                   nrst,
	input  core_l15_pkg::rqtype_t  transducer_l15_rqtype,
	input  core_l15_pkg::addr_t    transducer_l15_address,
	input  core_l15_pkg::line_t    transducer_l15_data,
	input  logic                   transducer_l15_val,
	output logic                   l15_transducer_ack,
	output logic                   l15_transducer_header_ack,
	output logic                   l15_transducer_val,
	output core_l15_pkg::line_t    l15_transducer_data_0,
	output core_l15_pkg::line_t    l15_transducer_data_1,
	output core_l15_pkg::rettype_t l15_transducer_returntype
);

	localparam int MEM_WORDS = 1024; // indexed by address bits 11:2

	core_l15_pkg::word_t   mem [MEM_WORDS]; // core byte order
	core_l15_pkg::addr_t   addr_q;
	core_l15_pkg::rqtype_t rq_q;
	integer                seed;
	int                    phase;
	int                    dly;
	int                    wake_cnt;
	logic                  woke;
	logic                  nrst_q; // reset level at the last rising edge

	function automatic core_l15_pkg::word_t swap_bytes(input core_l15_pkg::word_t w);
		return {w[7:0], w[15:8], w[23:16], w[31:24]};
	endfunction

	function automatic core_l15_pkg::rettype_t ret_for(input core_l15_pkg::rqtype_t rq);
		if (rq == core_l15_pkg::IFILL_RQ)
			return core_l15_pkg::IFILL_RET;
		else if (rq == core_l15_pkg::STORE_RQ)
			return core_l15_pkg::ST_ACK;
		return core_l15_pkg::LOAD_RET;
	endfunction

	task automatic clear_outputs();
		l15_transducer_ack        = 1'b0;
		l15_transducer_header_ack = 1'b0;
		l15_transducer_val        = 1'b0;
		l15_transducer_data_0     = '0;
		l15_transducer_data_1     = '0;
		l15_transducer_returntype = core_l15_pkg::LOAD_RET;
	endtask

	initial
	begin
		seed = 49536;
		for (int i = 0; i < MEM_WORDS; i++)
			mem[i] = $random(seed);
		clear_outputs();
	end

	always @(posedge clk)
		nrst_q <= nrst;

	always @(negedge clk)
	begin
		if (!nrst_q)
		begin
			clear_outputs();
			phase    = 0;
			woke     = 1'b0;
			wake_cnt = 12; // cycles until the wake-up return
		end
		else
		begin
			clear_outputs();
			if (!woke)
			begin
				if (wake_cnt == 0)
				begin
					l15_transducer_val        = 1'b1;
					l15_transducer_returntype = core_l15_pkg::INT_RET;
					woke                      = 1'b1;
				end
				else
					wake_cnt--;
			end
			else
			begin
				case (phase)
					0:
					begin
						if (transducer_l15_val)
						begin
							addr_q = transducer_l15_address;
							rq_q   = transducer_l15_rqtype;
							dly    = $random(seed) & 3;
							phase  = 1;
						end
					end
					1:
					begin
						if (dly == 0)
						begin
							l15_transducer_header_ack = 1'b1;
							if (rq_q == core_l15_pkg::STORE_RQ)
								mem[addr_q[11:2]] = swap_bytes(transducer_l15_data[63:32]);
							if (($random(seed) & 1) != 0)
							begin
								l15_transducer_ack = 1'b1; // ack together with header
								dly   = $random(seed) & 7;
								phase = 3;
							end
							else
							begin
								dly   = $random(seed) & 3;
								phase = 2;
							end
						end
						else
							dly--;
					end
					2:
					begin
						if (dly == 0)
						begin
							l15_transducer_ack = 1'b1;
							dly   = $random(seed) & 7;
							phase = 3;
						end
						else
							dly--;
					end
					default:
					begin
						if (dly == 0)
						begin
							l15_transducer_val        = 1'b1;
							l15_transducer_returntype = ret_for(rq_q);
							if (rq_q != core_l15_pkg::STORE_RQ)
							begin
								l15_transducer_data_0 = {swap_bytes(mem[{addr_q[11:4], 2'b00}]),
									swap_bytes(mem[{addr_q[11:4], 2'b01}])};
								l15_transducer_data_1 = {swap_bytes(mem[{addr_q[11:4], 2'b10}]),
									swap_bytes(mem[{addr_q[11:4], 2'b11}])};
							end
							phase = 0;
						end
						else
							dly--;
					end
				endcase
			end
		end
	end

endmodule

//--- testbench/tb_core_l15_front.sv
module tb_core_l15_front;

	localparam int RUN_CYCLES = 3000;
	localparam int MAX_LAT    = 24; // worst model latency plus arbiter turnaround
	// reset, wake-up, stimulus, then at most one fetch and one data op to drain
	localparam int TIMEOUT    = 10 + 16 + RUN_CYCLES + 2 * MAX_LAT + 50;

	logic                   clk = 1'b0;
	logic                   nrst;
	logic                   stall;
	logic                   redirect;
	logic                   exception_pending;
	logic                   mem_rd;
	logic                   mem_wr;
	core_l15_pkg::addr_t    target;
	core_l15_pkg::addr_t    epc;
	core_l15_pkg::addr_t    mem_addr;
	core_l15_pkg::word_t    mem_wdata;
	core_l15_pkg::word_t    instr;
	core_l15_pkg::addr_t    pc;
	logic                   instr_valid;
	logic                   instruction_addr_misaligned;
	logic                   mem_busy;
	core_l15_pkg::word_t    mem_rdata;
	logic                   mem_done;
	core_l15_pkg::rqtype_t  transducer_l15_rqtype;
	core_l15_pkg::size_t    transducer_l15_size;
	core_l15_pkg::addr_t    transducer_l15_address;
	core_l15_pkg::line_t    transducer_l15_data;
	logic                   transducer_l15_val;
	logic                   transducer_l15_req_ack;
	logic                   l15_transducer_ack;
	logic                   l15_transducer_header_ack;
	logic                   l15_transducer_val;
	core_l15_pkg::line_t    l15_transducer_data_0;
	core_l15_pkg::line_t    l15_transducer_data_1;
	core_l15_pkg::rettype_t l15_transducer_returntype;

	core_l15_pkg::word_t ref_mem [1024]; // reference memory image
	integer              seed;
	integer              fill_seed;
	core_l15_pkg::addr_t exp_pc;
	core_l15_pkg::addr_t op_addr;
	logic                woke = 1'b0;
	logic                first_seen = 1'b0;
	logic                op_pend = 1'b0;
	logic                op_store = 1'b0;
	int                  n_instr = 0;
	int                  n_done = 0;
	int                  cycles = 0;

	core_l15_front uut (.*);

	l15_model u_l15 (.*);

	always #20 clk = ~clk;

	task automatic stop_on_error(input string msg);
		$display("%s", msg);
		$display("** FAIL **");
		$fatal(1);
	endtask

	task automatic check_word(input string name, input core_l15_pkg::word_t got,
		input core_l15_pkg::word_t exp);
		if (got !== exp)
			stop_on_error($sformatf("CHECK FAILED %s: got %h, expected %h", name, got, exp));
	endtask

	task automatic check_addr(input string name, input core_l15_pkg::addr_t got,
		input core_l15_pkg::addr_t exp);
		if (got !== exp)
			stop_on_error($sformatf("CHECK FAILED %s: got %h, expected %h", name, got, exp));
	endtask

	task automatic check_size(input string name, input core_l15_pkg::size_t got,
		input core_l15_pkg::size_t exp);
		if (got !== exp)
			stop_on_error($sformatf("CHECK FAILED %s: got %h, expected %h", name, got, exp));
	endtask

	task automatic check_flag(input string name, input logic got, input logic exp);
		if (got !== exp)
			stop_on_error($sformatf("CHECK FAILED %s: got %h, expected %h", name, got, exp));
	endtask

	// fetch targets stay in the low 1 KiB, data ops use 0x800 and up
	function automatic core_l15_pkg::addr_t pick_target();
		core_l15_pkg::addr_t a;
		a = core_l15_pkg::RESET_PC | ($random(seed) & 32'h3fc);
		if (($random(seed) & 15) == 0)
			a = a + 32'd2; // misaligned now and then
		return a;
	endfunction

	task automatic drive_cycle();
		int r;
		redirect          = 1'b0;
		exception_pending = 1'b0;
		mem_rd            = 1'b0;
		mem_wr            = 1'b0;
		stall             = ($random(seed) & 7) == 0;
		if (first_seen)
		begin
			r = $random(seed) & 31;
			if (r == 0 || r == 2)
			begin
				redirect = 1'b1;
				target   = pick_target();
			end
			if (r == 1 || r == 2)
			begin
				exception_pending = 1'b1;
				epc               = pick_target();
			end
		end
		if (!mem_busy && !op_pend && ($random(seed) & 3) == 0)
		begin
			mem_addr  = 32'h4000_0800 | ($random(seed) & 32'h7fc);
			mem_wdata = $random(seed);
			op_store  = ($random(seed) & 1) != 0;
			mem_wr    = op_store;
			mem_rd    = !op_store;
			op_addr   = mem_addr;
			op_pend   = 1'b1;
			if (op_store)
				ref_mem[mem_addr[11:2]] = mem_wdata;
		end
	endtask

	// checks on the rising edge, before the DUT registers move
	always @(posedge clk)
	begin
		cycles++;
		if (cycles >= TIMEOUT)
			stop_on_error($sformatf("timeout, run did not finish in %0d cycles", TIMEOUT));
		if (nrst)
		begin
			if (l15_transducer_val && l15_transducer_returntype == core_l15_pkg::INT_RET)
				woke = 1'b1;
			if (instr_valid)
			begin
				if (!woke)
					stop_on_error("instruction returned before the wake-up return");
				check_addr("pc", pc, exp_pc);
				check_word("instr", instr, ref_mem[exp_pc[11:2]]);
				check_flag("instruction_addr_misaligned", instruction_addr_misaligned,
					|exp_pc[1:0]);
				n_instr++;
				first_seen = 1'b1;
			end
			else
				check_word("instr", instr, core_l15_pkg::NOP_INSTR); // idle or killed slot
			if (redirect || exception_pending)
				exp_pc = exception_pending ? epc : target; // exception wins
			else if (instr_valid)
				exp_pc = exp_pc + 32'd4;
			if (transducer_l15_val)
				check_size("transducer_l15_size", transducer_l15_size,
					core_l15_pkg::WORD_SIZE);
			check_flag("transducer_l15_req_ack", transducer_l15_req_ack, l15_transducer_val);
			// busy from the edge after the strobe, left open in the done cycle
			if (!mem_done)
				check_flag("mem_busy", mem_busy, op_pend && !mem_rd && !mem_wr);
			if (mem_done)
			begin
				if (!op_pend)
					stop_on_error("mem_done without an outstanding data operation");
				if (!op_store)
					check_word("mem_rdata", mem_rdata, ref_mem[op_addr[11:2]]);
				op_pend = 1'b0;
				n_done++;
			end
		end
	end

	initial
	begin
		seed      = 49536;
		fill_seed = 49536;
		for (int i = 0; i < 1024; i++)
			ref_mem[i] = $random(fill_seed); // same fill as the L1.5 model
		nrst              = 1'b0;
		stall             = 1'b0;
		redirect          = 1'b0;
		exception_pending = 1'b0;
		mem_rd            = 1'b0;
		mem_wr            = 1'b0;
		target            = core_l15_pkg::RESET_PC;
		epc               = core_l15_pkg::RESET_PC;
		mem_addr          = 32'h4000_0800;
		mem_wdata         = '0;
		exp_pc            = core_l15_pkg::RESET_PC;
		repeat (10) @(posedge clk);
		@(negedge clk);
		nrst = 1'b1;
		repeat (RUN_CYCLES)
		begin
			@(negedge clk);
			drive_cycle();
		end
		@(negedge clk);
		redirect          = 1'b0;
		exception_pending = 1'b0;
		mem_rd            = 1'b0;
		mem_wr            = 1'b0;
		while (op_pend)
			@(negedge clk);
		if (n_instr == 0 || n_done == 0)
		begin
			$display("no instruction or no data operation completed");
			$display("** FAIL **");
			$fatal(1);
		end
		else
		begin
			$display("** PASS **");
			$finish;
		end
	end

endmodule

//--- core_l15_front.f
hdl/core_l15_pkg.sv
hdl/fetch_unit.sv
hdl/data_port.sv
hdl/l15_arbiter.sv
hdl/core_l15_front.sv
testbench/l15_model.sv
testbench/tb_core_l15_front.sv

//--- Makefile
VERILATOR ?= verilator
TOP       ?= tb_core_l15_front
RTL_TOP   ?= core_l15_front
FILELIST  ?= core_l15_front.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -Wno-fatal
RTL_SRCS  ?= hdl/core_l15_pkg.sv hdl/fetch_unit.sv hdl/data_port.sv \
	hdl/l15_arbiter.sv hdl/core_l15_front.sv

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)

run: build
	-./$(BUILD_DIR)/V$(TOP) 2>&1 | tee $(LOG)
	@grep -q '^\*\* PASS \*\*$$' $(LOG) || (echo "simulation failed, see $(LOG)"; exit 1)

lint:
	$(VERILATOR) --lint-only --top-module $(RTL_TOP) $(RTL_SRCS)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
